// ==== src/sram_mbist_pkg.sv ====
// sram mbist shared sizes, March C- state encoding and background selects
`default_nettype none

package sram_mbist_pkg;

  // ====================================================================
  // default geometry of the SRAM under test
  // ====================================================================
  localparam int DEF_ADDR_W  = 10;
  localparam int DEF_DATA_W  = 32;
  localparam int DEF_DEPTH   = 1024;
  localparam int DEF_WMASK_W = 1;

  // ====================================================================
  // March C- sequencer states
  // ====================================================================
  // each element is a contiguous run of codes, so ranges decode an element
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_W0_U,
    // r0 w1, address up
    ST_R0W1_U_RD, ST_R0W1_U_CHK, ST_R0W1_U_WWAIT, ST_R0W1_U_WR, ST_R0W1_U_ADV,
    // r1 w0, address up
    ST_R1W0_U_RD, ST_R1W0_U_CHK, ST_R1W0_U_WWAIT, ST_R1W0_U_WR, ST_R1W0_U_ADV,
    // r0 only, address up
    ST_R0_U_RD, ST_R0_U_CHK, ST_R0_U_WAIT, ST_R0_U_ADV,
    // r0 w1, address down
    ST_R0W1_D_RD, ST_R0W1_D_CHK, ST_R0W1_D_WWAIT, ST_R0W1_D_WR, ST_R0W1_D_ADV,
    // r1 w0, address down
    ST_R1W0_D_RD, ST_R1W0_D_CHK, ST_R1W0_D_WWAIT, ST_R1W0_D_WR, ST_R1W0_D_ADV,
    // r0 only, address down
    ST_R0_D_RD, ST_R0_D_CHK, ST_R0_D_WAIT, ST_R0_D_ADV,
    ST_COMPLETE
  } march_state_t;

  // background select, one bit replicated over the whole word
  localparam logic BG_ZERO = 1'b0;
  localparam logic BG_ONE  = 1'b1;

endpackage

`default_nettype wire

// ==== src/mbist_step_if.sv ====
// step bundle from the March sequencer to pattern generator and checker
`timescale 1ns/1ps
`default_nettype none

interface mbist_step_if #(
  parameter int ADDR_W = sram_mbist_pkg::DEF_ADDR_W
);

  // address counter value of the current step
  logic [ADDR_W-1:0] addr;
  // write step and the background to write
  logic              wr_stb;
  logic              wr_bg;
  // compare step and the expected background
  logic              chk_stb;
  logic              chk_bg;
  // sequencer sitting in idle / complete
  logic              idle;
  logic              complete;

  // sequencer side drives everything
  modport ctrl (output addr, wr_stb, wr_bg, chk_stb, chk_bg, idle, complete);
  // write path only needs address and write info
  modport gen  (input addr, wr_stb, wr_bg);
  // read path only needs compare info and run status
  modport chk  (input chk_stb, chk_bg, idle, complete);

endinterface

`default_nettype wire

// ==== src/mbist_march_ctrl.sv ====
// March C- sequencer with up/down address counter and step decode
`timescale 1ns/1ps
`default_nettype none

module mbist_march_ctrl #(
  parameter int ADDR_W = sram_mbist_pkg::DEF_ADDR_W,
  parameter int DEPTH  = sram_mbist_pkg::DEF_DEPTH
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mbist_en,
  mbist_step_if.ctrl step
);
  import sram_mbist_pkg::*;

  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

  march_state_t      state;
  march_state_t      state_nxt;
  logic [ADDR_W-1:0] cnt;
  logic              cnt_up;
  logic              cnt_down;
  logic              cnt_last;
  logic              load_zero;
  logic              load_top;

  // ====================================================================
  // state machine
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:         if (mbist_en) state_nxt = ST_W0_U;
      // one write per address
      ST_W0_U:         if (cnt_last) state_nxt = ST_R0W1_U_RD;
      ST_R0W1_U_RD:    state_nxt = ST_R0W1_U_CHK;
      ST_R0W1_U_CHK:   state_nxt = ST_R0W1_U_WWAIT;
      ST_R0W1_U_WWAIT: state_nxt = ST_R0W1_U_WR;
      ST_R0W1_U_WR:    state_nxt = ST_R0W1_U_ADV;
      ST_R0W1_U_ADV:   state_nxt = cnt_last ? ST_R1W0_U_RD : ST_R0W1_U_RD;
      ST_R1W0_U_RD:    state_nxt = ST_R1W0_U_CHK;
      ST_R1W0_U_CHK:   state_nxt = ST_R1W0_U_WWAIT;
      ST_R1W0_U_WWAIT: state_nxt = ST_R1W0_U_WR;
      ST_R1W0_U_WR:    state_nxt = ST_R1W0_U_ADV;
      ST_R1W0_U_ADV:   state_nxt = cnt_last ? ST_R0_U_RD : ST_R1W0_U_RD;
      // read-only element, no write slot
      ST_R0_U_RD:      state_nxt = ST_R0_U_CHK;
      ST_R0_U_CHK:     state_nxt = ST_R0_U_WAIT;
      ST_R0_U_WAIT:    state_nxt = ST_R0_U_ADV;
      ST_R0_U_ADV:     state_nxt = cnt_last ? ST_R0W1_D_RD : ST_R0_U_RD;
      ST_R0W1_D_RD:    state_nxt = ST_R0W1_D_CHK;
      ST_R0W1_D_CHK:   state_nxt = ST_R0W1_D_WWAIT;
      ST_R0W1_D_WWAIT: state_nxt = ST_R0W1_D_WR;
      ST_R0W1_D_WR:    state_nxt = ST_R0W1_D_ADV;
      ST_R0W1_D_ADV:   state_nxt = cnt_last ? ST_R1W0_D_RD : ST_R0W1_D_RD;
      ST_R1W0_D_RD:    state_nxt = ST_R1W0_D_CHK;
      ST_R1W0_D_CHK:   state_nxt = ST_R1W0_D_WWAIT;
      ST_R1W0_D_WWAIT: state_nxt = ST_R1W0_D_WR;
      ST_R1W0_D_WR:    state_nxt = ST_R1W0_D_ADV;
      ST_R1W0_D_ADV:   state_nxt = cnt_last ? ST_R0_D_RD : ST_R1W0_D_RD;
      ST_R0_D_RD:      state_nxt = ST_R0_D_CHK;
      ST_R0_D_CHK:     state_nxt = ST_R0_D_WAIT;
      ST_R0_D_WAIT:    state_nxt = ST_R0_D_ADV;
      // last element done, go straight to complete
      ST_R0_D_ADV:     state_nxt = cnt_last ? ST_COMPLETE : ST_R0_D_RD;
      // hold result until test mode is dropped
      ST_COMPLETE:     if (!mbist_en) state_nxt = ST_IDLE;
      default:         state_nxt = ST_IDLE;
    endcase
  end

  // ====================================================================
  // address counter
  // ====================================================================
  assign cnt_up   = state inside {ST_W0_U, ST_R0W1_U_ADV, ST_R1W0_U_ADV, ST_R0_U_ADV};
  assign cnt_down = state inside {ST_R0W1_D_ADV, ST_R1W0_D_ADV, ST_R0_D_ADV};
  assign cnt_last = (cnt_up && cnt == LAST_ADDR) || (cnt_down && cnt == '0);

  // next element starts at bottom for up, top for down
  assign load_zero = (state inside {ST_W0_U, ST_R0W1_U_ADV, ST_R1W0_U_ADV})
                     && cnt == LAST_ADDR;
  assign load_top  = (state == ST_R0_U_ADV && cnt == LAST_ADDR)
                     || (cnt_down && cnt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (state == ST_IDLE) begin
      cnt <= '0;
    end else if (load_zero) begin
      cnt <= '0;
    end else if (load_top) begin
      cnt <= LAST_ADDR;
    end else if (cnt_up) begin
      cnt <= cnt + ADDR_W'(1);
    end else if (cnt_down) begin
      cnt <= cnt - ADDR_W'(1);
    end
  end

  // ====================================================================
  // step decode
  // ====================================================================
  assign step.addr   = cnt;
  assign step.wr_stb = state inside {ST_W0_U, ST_R0W1_U_WR, ST_R1W0_U_WR,
                                     ST_R0W1_D_WR, ST_R1W0_D_WR};
  // ones written only in the r0 w1 elements
  assign step.wr_bg  = (state inside {[ST_R0W1_U_RD:ST_R0W1_U_ADV],
                                      [ST_R0W1_D_RD:ST_R0W1_D_ADV]}) ? BG_ONE : BG_ZERO;
  // compare lands where the registered read data arrives
  assign step.chk_stb = state inside {ST_R0W1_U_WR, ST_R1W0_U_WR, ST_R0_U_ADV,
                                      ST_R0W1_D_WR, ST_R1W0_D_WR, ST_R0_D_ADV};
  // ones expected only in the r1 w0 elements
  assign step.chk_bg  = (state inside {[ST_R1W0_U_RD:ST_R1W0_U_ADV],
                                       [ST_R1W0_D_RD:ST_R1W0_D_ADV]}) ? BG_ONE : BG_ZERO;
  assign step.idle     = (state == ST_IDLE);
  assign step.complete = (state == ST_COMPLETE);

endmodule

`default_nettype wire

// ==== src/mbist_pattern_gen.sv ====
// test address/data/write-enable registers and SRAM port select
`timescale 1ns/1ps
`default_nettype none

module mbist_pattern_gen #(
  parameter int ADDR_W  = sram_mbist_pkg::DEF_ADDR_W,
  parameter int DATA_W  = sram_mbist_pkg::DEF_DATA_W,
  parameter int WMASK_W = sram_mbist_pkg::DEF_WMASK_W
) (
  input  logic               clk,
  input  logic               mbist_en,
  mbist_step_if.gen          step,
  // functional side
  input  logic               cen,
  input  logic               gwen,
  input  logic [WMASK_W-1:0] wen,
  input  logic [ADDR_W-1:0]  a,
  input  logic [DATA_W-1:0]  d,
  // SRAM side
  output logic               sram_cen,
  output logic               sram_gwen,
  output logic [WMASK_W-1:0] sram_wen,
  output logic [ADDR_W-1:0]  sram_a,
  output logic [DATA_W-1:0]  sram_d
);
  import sram_mbist_pkg::*;

  logic [ADDR_W-1:0] test_a;
  logic [DATA_W-1:0] test_d;
  logic              test_wen;

  // ====================================================================
  // test pipeline one cycle behind the sequencer
  // ====================================================================
  always_ff @(posedge clk) begin
    test_a   <= step.addr;
    // active low write enable
    test_wen <= ~step.wr_stb;
    // background bit spread over the word
    test_d   <= {DATA_W{step.wr_bg == BG_ONE}};
  end

  // ====================================================================
  // port select
  // ====================================================================
  // switches immediately with mbist_en, even mid-run
  // chip held selected (active low) in test mode
  assign sram_cen  = mbist_en ? 1'b0 : cen;
  assign sram_gwen = mbist_en ? test_wen : gwen;
  // all mask bits follow the global enable
  assign sram_wen  = mbist_en ? {WMASK_W{test_wen}} : wen;
  assign sram_a    = mbist_en ? test_a : a;
  assign sram_d    = mbist_en ? test_d : d;

endmodule

`default_nettype wire

// ==== src/mbist_response_check.sv ====
// read data compare, sticky fail flag, done and pass levels
`timescale 1ns/1ps
`default_nettype none

module mbist_response_check #(
  parameter int DATA_W = sram_mbist_pkg::DEF_DATA_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] sram_q,
  mbist_step_if.chk         step,
  output logic              mbist_done,
  output logic              mbist_pass
);
  import sram_mbist_pkg::*;

  logic [DATA_W-1:0] q_d;
  logic [DATA_W-1:0] exp_d;
  logic              mismatch;
  logic              fail;

  // ====================================================================
  // compare
  // ====================================================================
  // read data and expected word line up in the compare state
  always_ff @(posedge clk) begin
    q_d   <= sram_q;
    exp_d <= {DATA_W{step.chk_bg == BG_ONE}};
  end

  assign mismatch = step.chk_stb && (q_d != exp_d);

  // sticky until the sequencer goes back to idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fail <= 1'b0;
    end else if (step.idle) begin
      fail <= 1'b0;
    end else if (mismatch) begin
      fail <= 1'b1;
    end
  end

  // ====================================================================
  // status
  // ====================================================================
  // done trails complete by a cycle, pass is settled by then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mbist_done <= 1'b0;
      mbist_pass <= 1'b0;
    end else begin
      mbist_done <= step.complete;
      mbist_pass <= ~fail;
    end
  end

endmodule

`default_nettype wire

// ==== src/sram_mbist_top.sv ====
// March C- MBIST wrapper for one single-port synchronous SRAM
`timescale 1ns/1ps
`default_nettype none

module sram_mbist_top #(
  parameter int ADDR_W  = sram_mbist_pkg::DEF_ADDR_W,
  parameter int DATA_W  = sram_mbist_pkg::DEF_DATA_W,
  parameter int DEPTH   = sram_mbist_pkg::DEF_DEPTH,
  parameter int WMASK_W = sram_mbist_pkg::DEF_WMASK_W
) (
  input  logic               clk,
  input  logic               rst_n,
  // test control and result
  input  logic               mbist_en,
  output logic               mbist_done,
  output logic               mbist_pass,
  // functional port
  input  logic               cen,
  input  logic               gwen,
  input  logic [WMASK_W-1:0] wen,
  input  logic [ADDR_W-1:0]  a,
  input  logic [DATA_W-1:0]  d,
  // SRAM port
  output logic               sram_cen,
  output logic               sram_gwen,
  output logic [WMASK_W-1:0] sram_wen,
  output logic [ADDR_W-1:0]  sram_a,
  output logic [DATA_W-1:0]  sram_d,
  input  logic [DATA_W-1:0]  sram_q
);

  // sequencer to datapath
  mbist_step_if #(.ADDR_W(ADDR_W)) step ();

  mbist_march_ctrl #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) u_march_ctrl (
    .clk(clk), .rst_n(rst_n), .mbist_en(mbist_en), .step(step.ctrl)
  );

  mbist_pattern_gen #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WMASK_W(WMASK_W)
  ) u_pattern_gen (
    .clk(clk), .mbist_en(mbist_en), .step(step.gen),
    .cen(cen), .gwen(gwen), .wen(wen), .a(a), .d(d),
    .sram_cen(sram_cen), .sram_gwen(sram_gwen), .sram_wen(sram_wen),
    .sram_a(sram_a), .sram_d(sram_d)
  );

  mbist_response_check #(.DATA_W(DATA_W)) u_response_check (
    .clk(clk), .rst_n(rst_n), .sram_q(sram_q), .step(step.chk),
    .mbist_done(mbist_done), .mbist_pass(mbist_pass)
  );

endmodule

`default_nettype wire

// ==== verification/sram_model.sv ====
// behavioral single-port SRAM, one-cycle read, write counters, stuck-at fault
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int ADDR_W  = 4,
  parameter int DATA_W  = 8,
  parameter int DEPTH   = 16,
  parameter int WMASK_W = 1
) (
  input  logic                      clk,
  input  logic                      cen,
  input  logic                      gwen,
  input  logic [WMASK_W-1:0]        wen,
  input  logic [ADDR_W-1:0]         a,
  input  logic [DATA_W-1:0]         d,
  output logic [DATA_W-1:0]         q,
  // bench controls
  input  logic                      cnt_clr,
  input  logic                      fault_en,
  input  logic [ADDR_W-1:0]         fault_addr,
  input  logic [$clog2(DATA_W)-1:0] fault_bit,
  input  logic                      fault_val
);

  logic [DATA_W-1:0] mem [DEPTH];
  // writes seen per word since the last clear
  int                wr_cnt [DEPTH];
  logic              we;

  // whole word written only with every mask bit active
  assign we = !cen && !gwen && !(|wen);

  // forces the faulty cell, both on store and on read
  function automatic logic [DATA_W-1:0] with_fault(input logic [ADDR_W-1:0] adr,
                                                   input logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] r;
    r = word;
    if (fault_en && adr == fault_addr) begin
      r[fault_bit] = fault_val;
    end
    return r;
  endfunction

  // read returns old data on a write cycle
  always @(posedge clk) begin
    if (!cen) begin
      if (we) begin
        mem[a] <= with_fault(a, d);
      end
      q <= with_fault(a, mem[a]);
    end
  end

  always @(posedge clk) begin
    if (cnt_clr) begin
      foreach (wr_cnt[j]) wr_cnt[j] <= 0;
    end else if (we) begin
      wr_cnt[a] <= wr_cnt[a] + 1;
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_sram_mbist.sv ====
// directed testbench for the March C- SRAM MBIST wrapper
`timescale 1ns/1ps
`default_nettype none

module tb_sram_mbist;
  import sram_mbist_pkg::*;

  localparam int ADDR_W      = 4;
  localparam int DATA_W      = 8;
  localparam int DEPTH       = 16;
  localparam int WMASK_W     = DEF_WMASK_W;
  localparam int BIT_W       = $clog2(DATA_W);
  // full March C- run plus some slack
  localparam int RUN_TIMEOUT = 29 * DEPTH + 16;

  logic               clk;
  logic               rst_n;
  logic               mbist_en;
  logic               mbist_done;
  logic               mbist_pass;
  logic               cen;
  logic               gwen;
  logic [WMASK_W-1:0] wen;
  logic [ADDR_W-1:0]  a;
  logic [DATA_W-1:0]  d;
  logic               sram_cen;
  logic               sram_gwen;
  logic [WMASK_W-1:0] sram_wen;
  logic [ADDR_W-1:0]  sram_a;
  logic [DATA_W-1:0]  sram_d;
  logic [DATA_W-1:0]  sram_q;
  // fault and counter controls of the memory model
  logic               cnt_clr;
  logic               fault_en;
  logic [ADDR_W-1:0]  fault_addr;
  logic [BIT_W-1:0]   fault_bit;
  logic               fault_val;
  integer             seed;

  sram_mbist_top #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .DEPTH(DEPTH), .WMASK_W(WMASK_W)
  ) u_sram_mbist_top (
    .clk(clk), .rst_n(rst_n), .mbist_en(mbist_en),
    .mbist_done(mbist_done), .mbist_pass(mbist_pass),
    .cen(cen), .gwen(gwen), .wen(wen), .a(a), .d(d),
    .sram_cen(sram_cen), .sram_gwen(sram_gwen), .sram_wen(sram_wen),
    .sram_a(sram_a), .sram_d(sram_d), .sram_q(sram_q)
  );

  sram_model #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .DEPTH(DEPTH), .WMASK_W(WMASK_W)
  ) u_sram (
    .clk(clk), .cen(sram_cen), .gwen(sram_gwen), .wen(sram_wen), .a(sram_a),
    .d(sram_d), .q(sram_q), .cnt_clr(cnt_clr), .fault_en(fault_en),
    .fault_addr(fault_addr), .fault_bit(fault_bit), .fault_val(fault_val)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ====================================================================
  // compare and wait helpers
  // ====================================================================
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
  endtask

  // polls at the falling edge and gives up after a full run
  task automatic wait_done(input logic level);
    int           n;
    march_state_t st;
    n = 0;
    while (mbist_done !== level && n < RUN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (mbist_done !== level) begin
      st = u_sram_mbist_top.u_march_ctrl.state;
      fail_run($sformatf("mbist_done never reached %0b, sequencer stuck in %s",
                         level, st.name()));
    end
  endtask

  task automatic run_march();
    @(posedge clk);
    mbist_en <= 1'b1;
    @(negedge clk);
    wait_done(1'b1);
  endtask

  task automatic stop_march();
    @(posedge clk);
    mbist_en <= 1'b0;
    @(negedge clk);
    wait_done(1'b0);
  endtask

  task automatic inject_fault(input logic val);
    @(posedge clk);
    fault_en   <= 1'b1;
    fault_addr <= ADDR_W'($random(seed));
    fault_bit  <= BIT_W'($random(seed));
    fault_val  <= val;
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic test_passthrough();
    logic [ADDR_W-1:0] pa;
    logic [DATA_W-1:0] pd;
    pa = ADDR_W'($random(seed));
    pd = DATA_W'($random(seed));
    @(posedge clk);
    cen  <= 1'b0;
    gwen <= 1'b0;
    wen  <= '0;
    a    <= pa;
    d    <= pd;
    @(negedge clk);
    check_bit("sram_cen", sram_cen, 1'b0);
    check_bit("sram_gwen", sram_gwen, 1'b0);
    check_bit("sram_wen", |sram_wen, 1'b0);
    check_addr("sram_a", sram_a, pa);
    check_word("sram_d", sram_d, pd);
    // write lands on this edge and reads back on the next
    @(posedge clk);
    gwen <= 1'b1;
    wen  <= '1;
    @(posedge clk);
    @(negedge clk);
    check_bit("sram_gwen", sram_gwen, 1'b1);
    check_word("sram_q", sram_q, pd);
    @(posedge clk);
    cen <= 1'b1;
    // deselect must reach the SRAM too
    @(negedge clk);
    check_bit("sram_cen", sram_cen, 1'b1);
  endtask

  task automatic test_clean_run();
    int i;
    @(posedge clk);
    cnt_clr <= 1'b1;
    @(posedge clk);
    cnt_clr <= 1'b0;
    run_march();
    check_bit("mbist_pass", mbist_pass, 1'b1);
    // five writes per word (w0 w1 w0 w1 w0) and zeros left behind
    for (i = 0; i < DEPTH; i++) begin
      check_count($sformatf("wr_cnt[%0d]", i), u_sram.wr_cnt[i], 5);
      check_word($sformatf("mem[%0d]", i), u_sram.mem[i], '0);
    end
    stop_march();
  endtask

  task automatic test_stuck_at(input logic val);
    inject_fault(val);
    run_march();
    check_bit("mbist_pass", mbist_pass, 1'b0);
    stop_march();
    @(posedge clk);
    fault_en <= 1'b0;
  endtask

  task automatic test_hold_restart();
    int i;
    inject_fault(1'($random(seed)));
    run_march();
    check_bit("mbist_pass", mbist_pass, 1'b0);
    // result held as long as test mode stays on
    for (i = 0; i < 8; i++) begin
      @(negedge clk);
      check_bit("mbist_done", mbist_done, 1'b1);
    end
    stop_march();
    @(posedge clk);
    fault_en <= 1'b0;
    // fail flag must have cleared in idle
    run_march();
    check_bit("mbist_pass", mbist_pass, 1'b1);
    stop_march();
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    seed       = 32'h9099;
    rst_n      <= 1'b0;
    mbist_en   <= 1'b0;
    cen        <= 1'b1;
    gwen       <= 1'b1;
    wen        <= '1;
    a          <= '0;
    d          <= '0;
    cnt_clr    <= 1'b0;
    fault_en   <= 1'b0;
    fault_addr <= '0;
    fault_bit  <= '0;
    fault_val  <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("mbist_done", mbist_done, 1'b0);
    check_bit("mbist_pass", mbist_pass, 1'b0);
    test_passthrough();
    test_clean_run();
    test_stuck_at(1'b0);
    test_stuck_at(1'b1);
    test_hold_restart();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/sram_mbist_pkg.sv
src/mbist_step_if.sv
src/mbist_march_ctrl.sv
src/mbist_pattern_gen.sv
src/mbist_response_check.sv
src/sram_mbist_top.sv
verification/sram_model.sv
verification/tb_sram_mbist.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the MBIST testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
  --top-module tb_sram_mbist -o tb_sram_mbist \
  && ./obj_dir/tb_sram_mbist > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1
exit 0
